// File: common/adder_pkg.sv
// add/sub coprocessor shared definitions
// widths, register map, ctrl/status bit positions and AXI response codes
package adder_pkg;

  localparam int DATA_W = 32;  // operand and result width
  localparam int ADDR_W = 5;   // byte address into the register map

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [1:0]        resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // register offsets
  localparam addr_t REG_OPA    = 5'h00;  // r/w
  localparam addr_t REG_OPB    = 5'h04;  // r/w
  localparam addr_t REG_CTRL   = 5'h08;  // write only, reads zero
  localparam addr_t REG_RESULT = 5'h0C;  // read only
  localparam addr_t REG_STATUS = 5'h10;  // read only

  // ctrl word bits
  localparam int CTRL_GO  = 0;
  localparam int CTRL_SUB = 1;
  localparam int CTRL_CIN = 2;  // borrow when subtracting

  // status word bits
  localparam int ST_DONE  = 0;
  localparam int ST_CARRY = 1;
  localparam int ST_OVF   = 2;
  localparam int ST_ZERO  = 3;

  // write channel: idle, accept aw+w, hold bvalid
  typedef enum logic [1:0] {WR_IDLE, WR_ACK, WR_RESP} wr_state_t;

  // read channel: idle, accept ar, hold rvalid
  typedef enum logic [1:0] {RD_IDLE, RD_ACK, RD_DATA} rd_state_t;

endpackage

// File: common/alu_if.sv
// operand, control and result bundle between register block and alu core
`timescale 1ns/1ps

interface alu_if;
  import adder_pkg::*;

  data_t op_a;
  data_t op_b;
  logic  sub;
  logic  c_in;
  logic  start;   // one cycle pulse from the register block

  data_t result;
  logic  carry;   // borrow when the last op was a subtract
  logic  ovf;
  logic  zero;
  logic  done;

  modport regs (
    output op_a, op_b, sub, c_in, start,
    input  result, carry, ovf, zero, done
  );

  modport core (
    input  op_a, op_b, sub, c_in, start,
    output result, carry, ovf, zero, done
  );

endinterface

// File: hw/sklansky_adder/sklansky_adder.sv
// sklansky parallel-prefix adder, purely combinational
// c_in enters the tree as prefix node 0
`timescale 1ns/1ps

module sklansky_adder #(
  parameter int WIDTH = adder_pkg::DATA_W
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             c_in,
  output logic [WIDTH-1:0] sum,
  output logic             c_out
);

  // node k spans c_in and bits 0..k-1, so g[k] ends up as carry into bit k
  logic [WIDTH-1:0] g;
  logic [WIDTH-1:0] p;
  logic             g_top;
  logic             p_top;

  function automatic int min(input int x, input int y);
    return (x > y) ? y : x;
  endfunction

  // prefix cell, returns {g, p}
  function automatic logic [1:0] combine(
    input logic g_hi,
    input logic p_hi,
    input logic g_lo,
    input logic p_lo
  );
    logic g_o;
    logic p_o;
    g_o = g_hi | (p_hi & g_lo);
    p_o = p_hi & p_lo;
    return {g_o, p_o};
  endfunction

  always_comb begin
    g[0] = c_in;
    p[0] = 1'b0;  // nothing propagates past the carry-in node
    for (int k = 1; k < WIDTH; k++) begin
      g[k] = a[k-1] & b[k-1];
      p[k] = a[k-1] | b[k-1];
    end

    // each level folds the top node of the lower half into the upper half
    // of every block; nodes past WIDTH are cut by the min bound
    for (int lvl = 0; lvl < $clog2(WIDTH); lvl++) begin
      for (int m = 2**lvl - 1; m < WIDTH; m += 2**(lvl + 1)) begin
        for (int n = m + 1; n < min(WIDTH, m + 1 + 2**lvl); n++) begin
          {g[n], p[n]} = combine(g[n], p[n], g[m], p[m]);
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < WIDTH; k++) begin
      sum[k] = a[k] ^ b[k] ^ g[k];
    end
  end

  // top bit handled outside the tree
  assign g_top = a[WIDTH-1] & b[WIDTH-1];
  assign p_top = a[WIDTH-1] ^ b[WIDTH-1];
  assign c_out = g_top | (p_top & g[WIDTH-1]);

endmodule

// File: hw/alu_core.sv
// add/sub core around the sklansky adder
// registers result and flags on the start pulse
`timescale 1ns/1ps

module alu_core (
  input logic clk,
  input logic rst,
  alu_if.core alu
);
  import adder_pkg::*;

  data_t b_in;    // op_b after conditioning
  logic  cin_in;
  data_t sum;
  logic  c_out;

  data_t result_q;
  logic  carry_q;
  logic  ovf_q;
  logic  zero_q;
  logic  done_q;

  // subtract is a + ~b + ~c_in, so a set c_in takes one more off
  assign b_in   = alu.sub ? ~alu.op_b : alu.op_b;
  assign cin_in = alu.sub ? ~alu.c_in : alu.c_in;

  sklansky_adder #(
    .WIDTH(DATA_W)
  ) u_adder (
    .a    (alu.op_a),
    .b    (b_in),
    .c_in (cin_in),
    .sum  (sum),
    .c_out(c_out)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      result_q <= '0;
      carry_q  <= 1'b0;
      ovf_q    <= 1'b0;
      zero_q   <= 1'b0;
      done_q   <= 1'b0;
    end else if (alu.start) begin
      result_q <= sum;
      carry_q  <= c_out ^ alu.sub;  // inverted carry reads as borrow
      // same input signs, different result sign
      ovf_q    <= (alu.op_a[DATA_W-1] == b_in[DATA_W-1]) &&
                  (sum[DATA_W-1] != alu.op_a[DATA_W-1]);
      zero_q   <= (sum == '0);
      done_q   <= 1'b1;  // result lands on the start edge
    end
  end

  assign alu.result = result_q;
  assign alu.carry  = carry_q;
  assign alu.ovf    = ovf_q;
  assign alu.zero   = zero_q;
  assign alu.done   = done_q;

endmodule

// File: hw/axil_regs.sv
// AXI4-Lite slave with the coprocessor register map
// holds operands, issues the start pulse, muxes result and status
`timescale 1ns/1ps

module axil_regs (
  input  logic                          clk,
  input  logic                          rst,
  // write address
  input  adder_pkg::addr_t              awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  // write data, whole-word writes only so strobes are not decoded
  input  adder_pkg::data_t              wdata,
  input  logic [adder_pkg::DATA_W/8-1:0] wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  // write response
  output adder_pkg::resp_t              bresp,
  output logic                          bvalid,
  input  logic                          bready,
  // read address
  input  adder_pkg::addr_t              araddr,
  input  logic                          arvalid,
  output logic                          arready,
  // read data
  output adder_pkg::data_t              rdata,
  output adder_pkg::resp_t              rresp,
  output logic                          rvalid,
  input  logic                          rready,
  alu_if.regs                           alu
);
  import adder_pkg::*;

  wr_state_t wr_state;
  rd_state_t rd_state;

  data_t opa_q;
  data_t opb_q;
  logic  sub_q;
  logic  cin_q;
  logic  start_q;

  data_t status;
  data_t rd_word;
  logic  rd_err;

  // handshake outputs straight from state
  assign awready = (wr_state == WR_ACK);
  assign wready  = (wr_state == WR_ACK);
  assign bvalid  = (wr_state == WR_RESP);
  assign arready = (rd_state == RD_ACK);
  assign rvalid  = (rd_state == RD_DATA);

  // write channel and register updates
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= WR_IDLE;
      bresp    <= RESP_OKAY;
      opa_q    <= '0;
      opb_q    <= '0;
      sub_q    <= 1'b0;
      cin_q    <= 1'b0;
      start_q  <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (wr_state)
        WR_IDLE: begin
          if (awvalid && wvalid) wr_state <= WR_ACK;  // need both
        end
        WR_ACK: begin
          // transfer edge, aw and w are still held by the master
          wr_state <= WR_RESP;
          bresp    <= RESP_OKAY;
          case (awaddr)
            REG_OPA: opa_q <= wdata;
            REG_OPB: opb_q <= wdata;
            REG_CTRL: begin
              if (wdata[CTRL_GO]) begin
                sub_q   <= wdata[CTRL_SUB];
                cin_q   <= wdata[CTRL_CIN];
                start_q <= 1'b1;
              end
            end
            default: bresp <= RESP_SLVERR;  // read only or unmapped
          endcase
        end
        WR_RESP: begin
          if (bready) wr_state <= WR_IDLE;
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_comb begin
    status           = '0;
    status[ST_DONE]  = alu.done;
    status[ST_CARRY] = alu.carry;
    status[ST_OVF]   = alu.ovf;
    status[ST_ZERO]  = alu.zero;
  end

  // read decode
  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    case (araddr)
      REG_OPA:    rd_word = opa_q;
      REG_OPB:    rd_word = opb_q;
      REG_CTRL:   rd_word = '0;  // write only
      REG_RESULT: rd_word = alu.result;
      REG_STATUS: rd_word = status;
      default:    rd_err  = 1'b1;
    endcase
  end

  // read channel fsm
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (arvalid) rd_state <= RD_ACK;
        RD_ACK:  rd_state <= RD_DATA;
        RD_DATA: if (rready) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // read payload, held while rvalid waits
  always_ff @(posedge clk) begin
    if (rd_state == RD_ACK) begin
      rdata <= rd_word;
      rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign alu.op_a  = opa_q;
  assign alu.op_b  = opb_q;
  assign alu.sub   = sub_q;
  assign alu.c_in  = cin_q;
  assign alu.start = start_q;

endmodule

// File: hw/adder_top.sv
// add/sub coprocessor top level
// AXI4-Lite register block driving the sklansky adder core
`timescale 1ns/1ps

module adder_top (
  input  logic                           clk,
  input  logic                           rst,
  input  adder_pkg::addr_t               awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  adder_pkg::data_t               wdata,
  input  logic [adder_pkg::DATA_W/8-1:0] wstrb,
  input  logic                           wvalid,
  output logic                           wready,
  output adder_pkg::resp_t               bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  adder_pkg::addr_t               araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output adder_pkg::data_t               rdata,
  output adder_pkg::resp_t               rresp,
  output logic                           rvalid,
  input  logic                           rready
);

  alu_if u_alu_if ();

  axil_regs u_regs (
    .clk    (clk),
    .rst    (rst),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .alu    (u_alu_if.regs)
  );

  // core sees only the operand/result bundle
  alu_core u_core (
    .clk(clk),
    .rst(rst),
    .alu(u_alu_if.core)
  );

endmodule

// File: sim/adder_assert.sv
// protocol checks on the AXI4-Lite slave
// valid/ready holding, start pulse width, done after start, idle after reset
`timescale 1ns/1ps

module adder_assert (
  input logic             clk,
  input logic             rst,
  input logic             awvalid, awready, wvalid, wready,
  input logic             bvalid, bready, arvalid, arready,
  input logic             rvalid, rready,
  input adder_pkg::data_t rdata,
  input logic             start,
  input logic             done
);

  // a raised valid waits for its ready
  a_aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
    else $error("awvalid dropped before its transfer");
  a_w_hold: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
    else $error("wvalid dropped before its transfer");
  a_b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");
  a_ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
    else $error("arvalid dropped before its transfer");
  a_r_hold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");
  a_r_data: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> $stable(rdata))
    else $error("rdata changed while stalled");

  a_start_pulse: assert property (@(posedge clk) disable iff (rst) start |=> !start)
    else $error("start held longer than one cycle");
  a_done: assert property (@(posedge clk) disable iff (rst) start |=> done)
    else $error("done not set after start");

  a_rst_idle: assert property (@(posedge clk) rst |=> !bvalid && !rvalid)
    else $error("response valid right after reset");

endmodule

bind axil_regs adder_assert u_assert (
  .clk(clk), .rst(rst),
  .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
  .bvalid(bvalid), .bready(bready), .arvalid(arvalid), .arready(arready),
  .rvalid(rvalid), .rready(rready), .rdata(rdata),
  .start(start_q), .done(status[adder_pkg::ST_DONE])
);

// File: sim/tb_adder_top.sv
// testbench for the add/sub coprocessor
// AXI4-Lite transfers checked against an integer reference model
`timescale 1ns/1ps

module tb_adder_top;
  import adder_pkg::*;

  localparam int TIMEOUT = 40;  // cycles per wait loop

  logic                clk;
  logic                rst;
  addr_t               awaddr;
  addr_t               araddr;
  data_t               wdata;
  data_t               rdata;
  logic [DATA_W/8-1:0] wstrb;
  resp_t               bresp;
  resp_t               rresp;
  logic                awvalid, awready, wvalid, wready, bvalid, bready;
  logic                arvalid, arready, rvalid, rready;

  // queued by the stimulus, compared on the next rising edge
  string chk_name[$];
  data_t chk_got[$];
  data_t chk_exp[$];
  int    n_checks = 0;

  adder_top u_dut (.*);

  always #50 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic next_cycle(inout int cnt, input string what);
    @(negedge clk);
    cnt++;
    if (cnt > TIMEOUT) stop_run($sformatf("timeout: %s never completed", what));
  endtask

  task automatic expect_eq(input string name, input data_t got, input data_t exp);
    chk_name.push_back(name);
    chk_got.push_back(got);
    chk_exp.push_back(exp);
  endtask

  // expected {zero, ovf, carry, result} from plain integer arithmetic
  function automatic logic [DATA_W+2:0] ref_model(input data_t a, input data_t b,
                                                  input logic sub, input logic c_in);
    logic [DATA_W:0] wide;  // msb is carry for add, borrow for sub
    longint          s;     // exact signed value
    if (sub) begin
      wide = {1'b0, a} - {1'b0, b} - {{DATA_W{1'b0}}, c_in};
      s    = longint'($signed(a)) - longint'($signed(b)) - longint'(c_in);
    end else begin
      wide = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, c_in};
      s    = longint'($signed(a)) + longint'($signed(b)) + longint'(c_in);
    end
    return {(wide[DATA_W-1:0] == '0), (s > 64'sd2147483647 || s < -64'sd2147483648),
            wide[DATA_W], wide[DATA_W-1:0]};
  endfunction

  always @(posedge clk) begin
    string name;
    data_t got;
    data_t exp;
    while (chk_name.size() > 0) begin
      name = chk_name.pop_front();
      got  = chk_got.pop_front();
      exp  = chk_exp.pop_front();
      n_checks++;
      assert (got === exp) else
        stop_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  end

  // aw and w together, then b held off for hold cycles
  task automatic axi_write(input addr_t addr, input data_t data, input int hold,
                           output resp_t resp);
    int cnt;
    cnt = 0;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!(awready && wready)) next_cycle(cnt, "write address/data handshake");
    @(negedge clk);  // transfer on the edge just passed
    awvalid = 1'b0;
    wvalid  = 1'b0;
    cnt = 0;
    while (!bvalid) next_cycle(cnt, "write response");
    resp = bresp;
    repeat (hold) begin
      @(negedge clk);
      expect_eq("bvalid while stalled", data_t'(bvalid), 32'd1);
      expect_eq("bresp while stalled", data_t'(bresp), data_t'(resp));
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input addr_t addr, input int hold, output data_t data,
                          output resp_t resp);
    int cnt;
    cnt = 0;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) next_cycle(cnt, "read address handshake");
    @(negedge clk);
    arvalid = 1'b0;
    cnt = 0;
    while (!rvalid) next_cycle(cnt, "read data");
    data = rdata;
    resp = rresp;
    repeat (hold) begin
      @(negedge clk);
      expect_eq("rvalid while stalled", data_t'(rvalid), 32'd1);
      expect_eq("rdata while stalled", rdata, data);
    end
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // one full operation through the register map
  task automatic run_op(input data_t a, input data_t b, input logic sub,
                        input logic c_in, input int hold);
    logic [DATA_W+2:0] exp;
    data_t             ctrl;
    data_t             st_exp;
    data_t             rd;
    resp_t             resp;
    int                cnt;
    exp              = ref_model(a, b, sub, c_in);
    ctrl             = '0;
    ctrl[CTRL_GO]    = 1'b1;
    ctrl[CTRL_SUB]   = sub;
    ctrl[CTRL_CIN]   = c_in;
    st_exp           = '0;
    st_exp[ST_DONE]  = 1'b1;
    st_exp[ST_CARRY] = exp[DATA_W];
    st_exp[ST_OVF]   = exp[DATA_W+1];
    st_exp[ST_ZERO]  = exp[DATA_W+2];
    axi_write(REG_OPA, a, hold, resp);
    expect_eq("opa bresp", data_t'(resp), data_t'(RESP_OKAY));
    axi_write(REG_OPB, b, 0, resp);
    axi_write(REG_CTRL, ctrl, hold, resp);
    expect_eq("ctrl bresp", data_t'(resp), data_t'(RESP_OKAY));
    cnt = 0;
    axi_read(REG_STATUS, hold, rd, resp);
    while (!rd[ST_DONE]) begin
      next_cycle(cnt, "done flag poll");
      axi_read(REG_STATUS, 0, rd, resp);
    end
    expect_eq("status", rd, st_exp);
    axi_read(REG_RESULT, hold, rd, resp);
    expect_eq("result", rd, exp[DATA_W-1:0]);
    expect_eq("result rresp", data_t'(resp), data_t'(RESP_OKAY));
  endtask

  initial begin
    data_t             r;
    data_t             rd;
    data_t             keep;
    resp_t             resp;
    logic [DATA_W+2:0] exp_op;
    void'($urandom(32'heec7));
    clk     = 1'b0;
    rst     = 1'b1;
    awaddr  = '0;
    araddr  = '0;
    wdata   = '0;
    wstrb   = '1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    axi_read(REG_STATUS, 0, rd, resp);
    expect_eq("status after reset", rd, 32'h0);
    axi_read(REG_RESULT, 0, rd, resp);
    expect_eq("result after reset", rd, 32'h0);

    run_op(32'hffff_ffff, 32'h1, 1'b0, 1'b0, 0);  // wraps to zero, carry out
    run_op(32'h7fff_ffff, 32'h1, 1'b0, 1'b0, 0);  // positive overflow
    run_op(32'h0, 32'h0, 1'b1, 1'b0, 0);
    run_op(32'h0, 32'h0, 1'b1, 1'b1, 0);           // borrow in gives -1
    run_op(32'h8000_0000, 32'h1, 1'b1, 1'b0, 0);  // negative overflow

    for (int i = 0; i < 200; i++) begin
      r = $urandom();
      run_op($urandom(), $urandom(), 1'b0, r[0], 0);
    end
    for (int i = 0; i < 200; i++) begin
      r = $urandom();
      run_op($urandom(), $urandom(), 1'b1, r[0], 0);
    end
    for (int i = 0; i < 30; i++) begin
      r = $urandom();
      run_op($urandom(), $urandom(), r[1], r[0], $urandom_range(0, 5));
    end

    r = $urandom();
    keep = $urandom();
    axi_write(REG_OPA, r, 0, resp);
    axi_write(REG_OPB, keep, 0, resp);
    axi_read(REG_OPA, 0, rd, resp);
    expect_eq("opa readback", rd, r);
    axi_read(REG_OPB, 0, rd, resp);
    expect_eq("opb readback", rd, keep);
    axi_read(REG_CTRL, 0, rd, resp);
    expect_eq("ctrl read", rd, 32'h0);
    exp_op = ref_model(r, keep, 1'b1, 1'b0);
    run_op(r, keep, 1'b1, 1'b0, 0);
    axi_write(REG_RESULT, ~exp_op[DATA_W-1:0], 0, resp);
    expect_eq("result write bresp", data_t'(resp), data_t'(RESP_SLVERR));
    axi_write(5'h14, 32'h1234_5678, 0, resp);
    expect_eq("unmapped write bresp", data_t'(resp), data_t'(RESP_SLVERR));
    axi_read(REG_RESULT, 0, rd, resp);
    expect_eq("result after bad writes", rd, exp_op[DATA_W-1:0]);
    axi_read(5'h18, 0, rd, resp);
    expect_eq("unmapped rresp", data_t'(resp), data_t'(RESP_SLVERR));
    expect_eq("unmapped rdata", rd, 32'h0);

    repeat (2) @(negedge clk);
    if (chk_name.size() == 0 && n_checks > 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_run("compare process left checks unprocessed");
    end
  end

endmodule

// File: all.f
common/adder_pkg.sv
common/alu_if.sv
hw/sklansky_adder/sklansky_adder.sv
hw/alu_core.sv
hw/axil_regs.sv
hw/adder_top.sv
sim/adder_assert.sv
sim/tb_adder_top.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the coprocessor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_adder_top -f all.f \
  || { echo "build failed"; exit 1; }
./obj_dir/Vtb_adder_top > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
